// ==== eth_rx_pkg.sv ====
package eth_rx_pkg;

    // start-of-frame delimiter nibble, ends the run of 4'h5 preamble nibbles
    localparam logic [3:0]  SFD_NIBBLE     = 4'hD;

    // preamble nibbles before the framer gives up
    localparam logic [15:0] PREAMBLE_LIMIT = 16'd18;

    // reflected ieee 802.3 polynomial
    localparam logic [31:0] CRC_POLY_REFL  = 32'hEDB88320;

    // register value after data plus good fcs, no final inversion
    localparam logic [31:0] CRC_RESIDUE    = 32'hDEBB20E3;

    // line side receive states
    typedef enum logic [2:0]
    {
        IDLE,
        PREAMBLE,
        NIB0,
        NIB1,
        NIB2,
        NIB3
    } rx_state_e;

endpackage

// ==== rx_buf_pkg.sv ====
package rx_buf_pkg;

    // accepted frame length in 16-bit words, crc included
    localparam logic [9:0] MIN_WORDS = 10'd32;
    localparam logic [9:0] MAX_WORDS = 10'd761;

    // fcs takes the last two words of every frame
    localparam logic [9:0] CRC_WORDS = 10'd2;

    // read side states
    typedef enum logic [1:0]
    {
        RD_IDLE,
        RD_START,
        RD_DATA,
        RD_DONE
    } rd_state_e;

endpackage

// ==== rx_nibble_framer.sv ====
module rx_nibble_framer
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_init_done,
    input  logic        i_rx_dv,
    input  logic [3:0]  i_rx_nibble,
    output logic        o_frame_start,
    output logic [15:0] o_word,
    output logic        o_word_valid,
    output logic        o_frame_end
);

    eth_rx_pkg::rx_state_e state;
    eth_rx_pkg::rx_state_e state_nx;
    logic                  dv_d;
    logic [15:0]           pre_cnt;
    logic                  pre_timeout;
    logic                  data_st;
    logic [15:0]           word_q;

    // any of the four nibble slots
    assign data_st = (state == eth_rx_pkg::NIB0) || (state == eth_rx_pkg::NIB1) ||
                     (state == eth_rx_pkg::NIB2) || (state == eth_rx_pkg::NIB3);

    assign pre_timeout = (pre_cnt == eth_rx_pkg::PREAMBLE_LIMIT);

    // sfd consumed this cycle, timeout wins
    assign o_frame_start = (state == eth_rx_pkg::PREAMBLE) && !pre_timeout && i_rx_dv &&
                           (i_rx_nibble == eth_rx_pkg::SFD_NIBBLE);

    assign o_word = word_q;

    always_comb
    begin
        state_nx = state;
        case (state)
            eth_rx_pkg::IDLE:
                // only a fresh rising edge of dv opens a frame
                if (i_init_done && i_rx_dv && !dv_d)
                    state_nx = eth_rx_pkg::PREAMBLE;
            eth_rx_pkg::PREAMBLE:
                if (pre_timeout || !i_rx_dv)
                    state_nx = eth_rx_pkg::IDLE;
                else if (o_frame_start)
                    state_nx = eth_rx_pkg::NIB0;
            eth_rx_pkg::NIB0:
                state_nx = i_rx_dv ? eth_rx_pkg::NIB1 : eth_rx_pkg::IDLE;
            eth_rx_pkg::NIB1:
                state_nx = i_rx_dv ? eth_rx_pkg::NIB2 : eth_rx_pkg::IDLE;
            eth_rx_pkg::NIB2:
                state_nx = i_rx_dv ? eth_rx_pkg::NIB3 : eth_rx_pkg::IDLE;
            eth_rx_pkg::NIB3:
                state_nx = i_rx_dv ? eth_rx_pkg::NIB0 : eth_rx_pkg::IDLE;
            default:
                state_nx = eth_rx_pkg::IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state        <= eth_rx_pkg::IDLE;
            dv_d         <= 1'b0;
            pre_cnt      <= '0;
            o_word_valid <= 1'b0;
            o_frame_end  <= 1'b0;
        end
        else
        begin
            state   <= state_nx;
            dv_d    <= i_rx_dv;
            // preamble length, cleared outside preamble
            pre_cnt <= (state == eth_rx_pkg::PREAMBLE) ? pre_cnt + 1'b1 : '0;
            // word complete after the fourth nibble
            o_word_valid <= (state == eth_rx_pkg::NIB3) && i_rx_dv;
            // registered so it trails the last word by a cycle
            o_frame_end  <= data_st && !i_rx_dv;
        end
    end

    // nibble placement within the word, low nibble of each byte first
    always_ff @(posedge i_clk)
    begin
        if (i_rx_dv)
        begin
            case (state)
                eth_rx_pkg::NIB0: word_q[11:8]  <= i_rx_nibble;
                eth_rx_pkg::NIB1: word_q[15:12] <= i_rx_nibble;
                eth_rx_pkg::NIB2: word_q[3:0]   <= i_rx_nibble;
                eth_rx_pkg::NIB3: word_q[7:4]   <= i_rx_nibble;
                default:          word_q        <= word_q;
            endcase
        end
    end

    // a word only ever follows a data nibble
    a_no_word_outside_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_word_valid |-> !(state inside {eth_rx_pkg::IDLE, eth_rx_pkg::PREAMBLE}))
        else $error("framer: word valid in idle or preamble");

endmodule

// ==== rx_crc_check.sv ====
module rx_crc_check
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_frame_start,
    input  logic [15:0] i_word,
    input  logic        i_word_valid,
    output logic        o_crc_ok
);

    logic [31:0] crc;

    // one byte through the reflected crc, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] data);
        logic [31:0] c;
        c = crc_in;
        for (int i = 0; i < 8; i++)
        begin
            if (c[0] ^ data[i])
                c = (c >> 1) ^ eth_rx_pkg::CRC_POLY_REFL;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            crc <= '1;
        else if (i_frame_start)
            // preset for the next frame
            crc <= '1;
        else if (i_word_valid)
            // high byte arrived first on the line
            crc <= crc_byte(crc_byte(crc, i_word[15:8]), i_word[7:0]);
    end

    // residue match means data plus fcs is consistent
    assign o_crc_ok = (crc == eth_rx_pkg::CRC_RESIDUE);

endmodule

// ==== rx_packet_store.sv ====
module rx_packet_store
#(
    parameter int ADDR_W   = 10,
    parameter int DESC_NUM = 10
)
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_frame_start,
    input  logic [15:0]       i_word,
    input  logic              i_word_valid,
    input  logic              i_frame_end,
    input  logic              i_crc_ok,
    input  logic              i_desc_pop,
    input  logic              i_rd_en,
    input  logic [ADDR_W-1:0] i_rd_addr,
    output logic              o_desc_valid,
    output logic [ADDR_W-1:0] o_desc_head,
    output logic [9:0]        o_desc_len,
    output logic [15:0]       o_rd_data
);

    localparam int DEPTH  = 1 << ADDR_W;
    localparam int SLOT_W = (DESC_NUM > 1) ? $clog2(DESC_NUM) : 1;
    localparam int OCC_W  = $clog2(DESC_NUM + 1);

    logic [15:0]       mem [0:DEPTH-1];
    logic [ADDR_W-1:0] desc_head [0:DESC_NUM-1];
    logic [9:0]        desc_len [0:DESC_NUM-1];

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] head_ptr;
    logic [9:0]        word_cnt;
    logic              too_long;
    logic              wr_word;
    logic              len_ok;
    logic              ring_full;
    logic              commit;
    logic [SLOT_W-1:0] wr_slot;
    logic [SLOT_W-1:0] rd_slot;
    logic [OCC_W-1:0]  occ;

    // stop writing once the frame passes the max length
    assign wr_word   = i_word_valid && !too_long && (word_cnt != rx_buf_pkg::MAX_WORDS);
    assign len_ok    = !too_long && (word_cnt >= rx_buf_pkg::MIN_WORDS);
    assign ring_full = (occ == OCC_W'(DESC_NUM));
    // keep the frame only if crc, length and a free slot all agree
    assign commit    = i_frame_end && i_crc_ok && len_ok && !ring_full;

    // write pointer and current frame bookkeeping
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr   <= '0;
            head_ptr <= '0;
            word_cnt <= '0;
            too_long <= 1'b0;
        end
        else if (i_frame_start)
        begin
            head_ptr <= wr_ptr;
            word_cnt <= '0;
            too_long <= 1'b0;
        end
        else if (i_word_valid)
        begin
            if (wr_word)
            begin
                wr_ptr   <= wr_ptr + 1'b1;
                word_cnt <= word_cnt + 1'b1;
            end
            else
                too_long <= 1'b1;
        end
        else if (i_frame_end && !commit)
            // rejected, give the space back
            wr_ptr <= head_ptr;
    end

    // descriptor ring indices and fill level
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_slot <= '0;
            rd_slot <= '0;
            occ     <= '0;
        end
        else
        begin
            if (commit)
                wr_slot <= (wr_slot == SLOT_W'(DESC_NUM - 1)) ? '0 : wr_slot + 1'b1;
            if (i_desc_pop)
                rd_slot <= (rd_slot == SLOT_W'(DESC_NUM - 1)) ? '0 : rd_slot + 1'b1;
            case ({commit, i_desc_pop})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
        end
    end

    // descriptor contents
    always_ff @(posedge i_clk)
    begin
        if (commit)
        begin
            desc_head[wr_slot] <= head_ptr;
            desc_len[wr_slot]  <= word_cnt;
        end
    end

    // word ram, one write and one registered read port
    always_ff @(posedge i_clk)
    begin
        if (wr_word)
            mem[wr_ptr] <= i_word;
        if (i_rd_en)
            o_rd_data <= mem[i_rd_addr];
    end

    // oldest committed frame
    assign o_desc_valid = (occ != '0);
    assign o_desc_head  = desc_head[rd_slot];
    assign o_desc_len   = desc_len[rd_slot];

    a_pop_when_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_desc_pop |-> o_desc_valid)
        else $error("store: descriptor pop on empty ring");

    a_occ_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        occ <= OCC_W'(DESC_NUM))
        else $error("store: descriptor count above ring size");

endmodule

// ==== rx_packet_reader.sv ====
module rx_packet_reader
#(
    parameter int ADDR_W = 10
)
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_desc_valid,
    input  logic [ADDR_W-1:0] i_desc_head,
    input  logic [9:0]        i_desc_len,
    input  logic [15:0]       i_rd_data,
    output logic              o_desc_pop,
    output logic              o_rd_en,
    output logic [ADDR_W-1:0] o_rd_addr,
    output logic [15:0]       o_data,
    output logic              o_data_valid,
    output logic [ADDR_W-1:0] o_recv_addr
);

    rx_buf_pkg::rd_state_e state;
    rx_buf_pkg::rd_state_e state_nx;
    logic [ADDR_W-1:0]     addr;
    logic [9:0]            remain;

    // descriptor taken in the start state
    assign o_desc_pop = (state == rx_buf_pkg::RD_START);
    assign o_rd_en    = (state == rx_buf_pkg::RD_DATA);
    assign o_rd_addr  = addr;
    // ram output lines up with the delayed valid
    assign o_data     = i_rd_data;

    always_comb
    begin
        state_nx = state;
        case (state)
            rx_buf_pkg::RD_IDLE:
                if (i_desc_valid)
                    state_nx = rx_buf_pkg::RD_START;
            rx_buf_pkg::RD_START:
                state_nx = rx_buf_pkg::RD_DATA;
            rx_buf_pkg::RD_DATA:
                // last payload word, crc words never read
                if (remain == 10'd1)
                    state_nx = rx_buf_pkg::RD_DONE;
            rx_buf_pkg::RD_DONE:
                state_nx = rx_buf_pkg::RD_IDLE;
            default:
                state_nx = rx_buf_pkg::RD_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state        <= rx_buf_pkg::RD_IDLE;
            addr         <= '0;
            remain       <= '0;
            o_data_valid <= 1'b0;
            o_recv_addr  <= '0;
        end
        else
        begin
            state <= state_nx;
            if (state == rx_buf_pkg::RD_START)
            begin
                addr   <= i_desc_head;
                remain <= i_desc_len - rx_buf_pkg::CRC_WORDS;
            end
            else if (state == rx_buf_pkg::RD_DATA)
            begin
                // wraps at the end of the buffer
                addr   <= addr + 1'b1;
                remain <= remain - 1'b1;
            end
            o_data_valid <= o_rd_en;
            // word index within the frame
            o_recv_addr  <= o_data_valid ? o_recv_addr + 1'b1 : '0;
        end
    end

    a_no_data_in_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_data_valid |-> (state != rx_buf_pkg::RD_IDLE))
        else $error("reader: data valid while idle");

endmodule

// ==== eth_rx_top.sv ====
module eth_rx_top
#(
    parameter int ADDR_W   = 10,
    parameter int DESC_NUM = 10
)
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_init_done,
    input  logic              i_rx_dv,
    input  logic [3:0]        i_rx_nibble,
    output logic [15:0]       o_data,
    output logic              o_data_valid,
    output logic [ADDR_W-1:0] o_recv_addr
);

    // framer to crc and store
    logic              frame_start;
    logic [15:0]       word;
    logic              word_valid;
    logic              frame_end;
    logic              crc_ok;
    // store to reader
    logic              desc_valid;
    logic [ADDR_W-1:0] desc_head;
    logic [9:0]        desc_len;
    logic              desc_pop;
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    logic [15:0]       rd_data;

    rx_nibble_framer u_framer
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_init_done   (i_init_done),
        .i_rx_dv       (i_rx_dv),
        .i_rx_nibble   (i_rx_nibble),
        .o_frame_start (frame_start),
        .o_word        (word),
        .o_word_valid  (word_valid),
        .o_frame_end   (frame_end)
    );

    rx_crc_check u_crc
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_frame_start (frame_start),
        .i_word        (word),
        .i_word_valid  (word_valid),
        .o_crc_ok      (crc_ok)
    );

    rx_packet_store #(
        .ADDR_W   (ADDR_W),
        .DESC_NUM (DESC_NUM)
    ) u_store
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_frame_start (frame_start),
        .i_word        (word),
        .i_word_valid  (word_valid),
        .i_frame_end   (frame_end),
        .i_crc_ok      (crc_ok),
        .i_desc_pop    (desc_pop),
        .i_rd_en       (rd_en),
        .i_rd_addr     (rd_addr),
        .o_desc_valid  (desc_valid),
        .o_desc_head   (desc_head),
        .o_desc_len    (desc_len),
        .o_rd_data     (rd_data)
    );

    rx_packet_reader #(
        .ADDR_W (ADDR_W)
    ) u_reader
    (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_desc_valid (desc_valid),
        .i_desc_head  (desc_head),
        .i_desc_len   (desc_len),
        .i_rd_data    (rd_data),
        .o_desc_pop   (desc_pop),
        .o_rd_en      (rd_en),
        .o_rd_addr    (rd_addr),
        .o_data       (o_data),
        .o_data_valid (o_data_valid),
        .o_recv_addr  (o_recv_addr)
    );

endmodule

// ==== tb_eth_rx_top.sv ====
module tb_eth_rx_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W     = 10;
    localparam int DESC_NUM   = 10;
    localparam int RESET_CYC  = 8;
    localparam int GAP_CYC    = 12;
    localparam int GOOD_MIN   = 32;
    localparam int GOOD_MAX   = 200;
    localparam int LONG_MAX   = 800;
    localparam int PRE_NIB    = 15;
    localparam int LONG_PRE   = 25;
    localparam int NUM_FRAMES = 33;
    localparam int DRAIN_CYC  = 2000;
    // four nibbles per word, plus preamble, sfd and gap per frame
    localparam int WATCHDOG_CYC = RESET_CYC + NUM_FRAMES * (GOOD_MAX * 4 + 16 + GAP_CYC) +
                                  LONG_MAX * 4 + 2 * DRAIN_CYC;

    logic              i_clk;
    logic              i_rst_n;
    logic              i_init_done;
    logic              i_rx_dv;
    logic [3:0]        i_rx_nibble;
    logic [15:0]       o_data;
    logic              o_data_valid;
    logic [ADDR_W-1:0] o_recv_addr;

    logic [31:0]        rng_state;
    // expected {word index, payload word}, one entry per output cycle
    logic [ADDR_W+15:0] exp_q [$];
    string              name_q [$];
    logic [ADDR_W+15:0] exp_entry;
    string              exp_name;
    int                 error_cnt;
    int                 check_cnt;

    eth_rx_top #(
        .ADDR_W   (ADDR_W),
        .DESC_NUM (DESC_NUM)
    ) UUT
    (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_init_done  (i_init_done),
        .i_rx_dv      (i_rx_dv),
        .i_rx_nibble  (i_rx_nibble),
        .o_data       (o_data),
        .o_data_valid (o_data_valid),
        .o_recv_addr  (o_recv_addr)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // lcg step
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int random_range(input int lo, input int hi);
        logic [31:0] r;
        r = next_random();
        return lo + int'(r % 32'(hi - lo + 1));
    endfunction

    // reflected crc-32, one byte, lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        logic        fb;
        r = c;
        for (int i = 0; i < 8; i++)
        begin
            fb = r[0] ^ b[i];
            r  = r >> 1;
            if (fb)
                r = r ^ eth_rx_pkg::CRC_POLY_REFL;
        end
        return r;
    endfunction

    // one nibble per clock, driven just after the edge
    task automatic drive_nibble(input logic dv, input logic [3:0] nib);
        @(posedge i_clk);
        #5;
        i_rx_dv     = dv;
        i_rx_nibble = nib;
    endtask

    task automatic idle_gap();
        repeat (GAP_CYC) drive_nibble(1'b0, 4'h0);
    endtask

    // n_words counts the two fcs words too
    task automatic send_frame(input string name, input int n_words, input bit corrupt,
                              input int n_pre);
        logic [7:0]  bytes [$];
        logic [31:0] crc;
        logic [31:0] r;
        int          pos;
        bit          accept;
        crc = '1;
        for (int i = 0; i < 2 * (n_words - 2); i++)
        begin
            r = next_random();
            bytes.push_back(r[7:0]);
            crc = crc_step(crc, r[7:0]);
        end
        // fcs is the inverted register, low byte first
        crc = ~crc;
        for (int i = 0; i < 4; i++)
            bytes.push_back(crc[8*i +: 8]);
        if (corrupt)
        begin
            // single bit error somewhere in the payload
            pos = random_range(0, 2 * (n_words - 2) - 1);
            r = next_random();
            bytes[pos] = bytes[pos] ^ (8'h01 << r[2:0]);
        end
        // a preamble past the limit loses the whole burst
        accept = i_init_done && !corrupt && (n_pre < int'(eth_rx_pkg::PREAMBLE_LIMIT)) &&
                 (n_words >= int'(rx_buf_pkg::MIN_WORDS)) &&
                 (n_words <= int'(rx_buf_pkg::MAX_WORDS));
        if (accept)
        begin
            // first byte on the line lands in the high half
            for (int k = 0; k < n_words - 2; k++)
            begin
                exp_q.push_back({ADDR_W'(k), bytes[2*k], bytes[2*k+1]});
                name_q.push_back(name);
            end
        end
        repeat (n_pre) drive_nibble(1'b1, 4'h5);
        drive_nibble(1'b1, eth_rx_pkg::SFD_NIBBLE);
        foreach (bytes[i])
        begin
            drive_nibble(1'b1, bytes[i][3:0]);
            drive_nibble(1'b1, bytes[i][7:4]);
        end
        idle_gap();
    endtask

    // outputs settle after the rising edge, sampled mid-cycle
    always @(negedge i_clk)
    begin
        if (i_rst_n && o_data_valid)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                $display("Error: output word %h arrived with no frame expected", o_data);
                error_cnt++;
            end
            if (exp_q.size() != 0)
            begin
                exp_entry = exp_q.pop_front();
                exp_name  = name_q.pop_front();
                check_cnt++;
                assert (o_data == exp_entry[15:0])
                else
                begin
                    $display("Fail %s data: expected %h, actual %h",
                             exp_name, exp_entry[15:0], o_data);
                    error_cnt++;
                end
                assert (o_recv_addr == exp_entry[ADDR_W+15:16])
                else
                begin
                    $display("Fail %s recv_addr: expected %0d, actual %0d",
                             exp_name, exp_entry[ADDR_W+15:16], o_recv_addr);
                    error_cnt++;
                end
            end
        end
    end

    initial
    begin
        int drain;
        i_rst_n     = 1'b0;
        i_init_done = 1'b0;
        i_rx_dv     = 1'b0;
        i_rx_nibble = 4'h0;
        rng_state   = 32'hf8cb14d3;
        error_cnt   = 0;
        check_cnt   = 0;
        drain       = 0;
        repeat (RESET_CYC) @(posedge i_clk);
        #5;
        i_rst_n = 1'b1;
        @(negedge i_clk);
        assert (!o_data_valid && (o_recv_addr == '0))
        else
        begin
            $display("Error: outputs not idle after reset");
            error_cnt++;
        end

        // link still initialising, nothing may come out
        for (int i = 0; i < 2; i++)
            send_frame("init_low", random_range(GOOD_MIN, GOOD_MAX), 1'b0, PRE_NIB);
        i_init_done = 1'b1;

        for (int i = 0; i < 20; i++)
            send_frame("good", random_range(GOOD_MIN, GOOD_MAX), 1'b0, PRE_NIB);

        for (int i = 0; i < 3; i++)
        begin
            send_frame("bad_crc", random_range(GOOD_MIN, GOOD_MAX), 1'b1, PRE_NIB);
            send_frame("after_bad_crc", random_range(GOOD_MIN, GOOD_MAX), 1'b0, PRE_NIB);
        end

        // both ends of the length window
        send_frame("short", random_range(4, int'(rx_buf_pkg::MIN_WORDS) - 1), 1'b0, PRE_NIB);
        send_frame("long", random_range(int'(rx_buf_pkg::MAX_WORDS) + 1, LONG_MAX), 1'b0,
                   PRE_NIB);
        send_frame("after_length", random_range(GOOD_MIN, GOOD_MAX), 1'b0, PRE_NIB);

        // preamble with no sfd, framer must time out
        repeat (LONG_PRE) drive_nibble(1'b1, 4'h5);
        idle_gap();
        // same long preamble, then an sfd and a good frame in the same burst
        send_frame("preamble_timeout", random_range(GOOD_MIN, GOOD_MAX), 1'b0, LONG_PRE);
        send_frame("after_timeout", random_range(GOOD_MIN, GOOD_MAX), 1'b0, PRE_NIB);

        while ((exp_q.size() != 0) && (drain < DRAIN_CYC))
        begin
            @(posedge i_clk);
            drain++;
        end
        // catch any stray words after the last frame
        repeat (50) @(posedge i_clk);
        assert (exp_q.size() == 0)
        else
        begin
            $display("Error: %0d expected words never came out", exp_q.size());
            error_cnt++;
        end

        $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYC) @(posedge i_clk);
        $display("Error: watchdog expired, %0d words still expected", exp_q.size());
        $display("checks: %0d, errors: %0d", check_cnt, error_cnt + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== eth_rx_top.f ====
eth_rx_pkg.sv
rx_buf_pkg.sv
rx_nibble_framer.sv
rx_crc_check.sv
rx_packet_store.sv
rx_packet_reader.sv
eth_rx_top.sv
tb_eth_rx_top.sv

// ==== Makefile ====
TOP := tb_eth_rx_top

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f eth_rx_top.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
